//--- src/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Datapath width, fixed by the ISA
`define dataWidth 16

// Architectural register count
`define regCount 16

// Bits needed to name one register
`define regIdWidth 4

// Flag bits in ZF, VF, NF order
`define flagCount 3

`endif

//--- src/cpuPkg.sv
`include "cpu_settings.svh"

package cpuPkg;

  // Sixteen opcodes, ADD doubles as the NOP opcode
  typedef enum logic [3:0] {
    opAdd    = 4'h0,
    opSub    = 4'h1,
    opXor    = 4'h2,
    opRed    = 4'h3,
    opSll    = 4'h4,
    opSra    = 4'h5,
    opRor    = 4'h6,
    opPaddsb = 4'h7,
    opLw     = 4'h8,
    opSw     = 4'h9,
    opLlb    = 4'hA,
    opLhb    = 4'hB,
    opB      = 4'hC,
    opBr     = 4'hD,
    opPcs    = 4'hE,
    opHlt    = 4'hF
  } opcodeT;

  ////////////////////////////////////////////////////////////
  // Instruction word, register view and branch view
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    opcodeT                  opcode;
    logic [`regIdWidth-1:0] rd;
    logic [`regIdWidth-1:0] rs;   // Upper nibble of the LLB/LHB immediate
    logic [`regIdWidth-1:0] rt;   // Also the 4-bit immediate
  } regFormatT;

  typedef struct packed {
    opcodeT     opcode;
    logic [2:0] cond;     // Condition code
    logic [8:0] offset;   // Halfword offset, signed
  } branchFormatT;

  typedef union packed {
    regFormatT    r;
    branchFormatT b;
  } instrT;

  // Raw control unit outputs
  typedef struct packed {
    logic   isBranch;
    opcodeT aluOp;
    logic   aluSrc;     // Immediate as second operand
    logic   regSrc;     // LLB/LHB read rd as first source
    logic   zEn;
    logic   nvEn;
    logic   memEnable;
    logic   memWrite;
    logic   regWrite;
    logic   memToReg;
    logic   hlt;
    logic   pcs;
  } ctrlT;

  ////////////////////////////////////////////////////////////
  // Stage bundles
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [`regIdWidth-1:0] srcReg1;
    logic [`regIdWidth-1:0] srcReg2;
    logic [`dataWidth-1:0]  aluIn1;
    logic [`dataWidth-1:0]  aluImm;
    logic [`dataWidth-1:0]  aluIn2;
    opcodeT                 aluOp;
    logic                   aluSrc;
    logic                   zEn;
    logic                   nvEn;
  } exSignalsT;   // 63 bits

  typedef struct packed {
    logic [`dataWidth-1:0] memWriteData;
    logic                  memEnable;
    logic                  memWrite;
  } memSignalsT;  // 18 bits

  typedef struct packed {
    logic [`regIdWidth-1:0] regRd;
    logic                   regWrite;
    logic                   memToReg;
    logic                   hlt;
    logic                   pcs;
  } wbSignalsT;   // 8 bits

  typedef struct packed {
    logic                  isBr;
    logic                  actualTaken;
    logic                  wenBht;
    logic                  wenBtb;
    logic [`dataWidth-1:0] branchTarget;
    logic [`dataWidth-1:0] actualTarget;
    logic                  updatePc;     // Redirect fetch
  } branchResultT;

  // Register file write port from MEM/WB
  typedef struct packed {
    logic                   regWrite;
    logic [`regIdWidth-1:0] regRd;
    logic [`dataWidth-1:0]  data;
  } writeBackT;

endpackage

//--- src/controlUnit.sv
`timescale 1ns/1ps

module controlUnit import cpuPkg::*; (
  input  opcodeT opcode,
  output ctrlT   ctrl
);

  // One case on the opcode, everything defaults low
  always_comb begin
    ctrl       = '0;
    ctrl.aluOp = opcode;   // ALU takes the opcode as its op select
    unique case (opcode)
      opAdd, opSub: begin
        ctrl.regWrite = 1'b1;
        ctrl.zEn      = 1'b1;
        ctrl.nvEn     = 1'b1;   // Overflow and sign from the adder
      end
      opXor: begin
        ctrl.regWrite = 1'b1;
        ctrl.zEn      = 1'b1;
      end
      opRed: begin
        ctrl.regWrite = 1'b1;   // Reduction leaves flags alone
      end
      opSll, opSra, opRor: begin
        ctrl.regWrite = 1'b1;
        ctrl.zEn      = 1'b1;
        ctrl.aluSrc   = 1'b1;   // Shift amount from the immediate
      end
      opPaddsb: begin
        ctrl.regWrite = 1'b1;
        ctrl.nvEn     = 1'b1;
      end
      opLw: begin
        ctrl.aluSrc    = 1'b1;  // Base plus offset
        ctrl.memEnable = 1'b1;
        ctrl.memToReg  = 1'b1;
        ctrl.regWrite  = 1'b1;
      end
      opSw: begin
        ctrl.aluSrc    = 1'b1;
        ctrl.memEnable = 1'b1;
        ctrl.memWrite  = 1'b1;
      end
      opLlb, opLhb: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.regSrc   = 1'b1;   // Merge into rd, so rd is also a source
        ctrl.regWrite = 1'b1;
      end
      opB, opBr: begin
        ctrl.isBranch = 1'b1;
      end
      opPcs: begin
        ctrl.pcs      = 1'b1;   // Writes pcNext into rd
        ctrl.regWrite = 1'b1;
      end
      opHlt: begin
        ctrl.hlt = 1'b1;
      end
    endcase
  end

endmodule

//--- src/branchControl.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module branchControl import cpuPkg::*; (
  input  logic [2:0]            cond,
  input  logic [8:0]            offset,
  input  logic [`flagCount-1:0] flags,
  input  logic [`dataWidth-1:0] rsData,
  input  logic                  isBranch,
  input  logic                  isBr,
  input  logic [`dataWidth-1:0] pcNext,
  input  logic [`dataWidth-1:0] predictedTarget,
  output branchResultT          result
);

  logic                  zf;
  logic                  vf;
  logic                  nf;
  logic                  condMet;     // Condition true for current flags
  logic [`dataWidth-1:0] offsetExt;   // Sign-extended, in bytes

  assign {zf, vf, nf} = flags;        // ZF high, NF low

  // Condition code table
  always_comb begin
    unique case (cond)
      3'b000:  condMet = !zf;         // NE
      3'b001:  condMet = zf;          // EQ
      3'b010:  condMet = !zf && !nf;  // GT
      3'b011:  condMet = nf;          // LT
      3'b100:  condMet = zf || !nf;   // GE
      3'b101:  condMet = nf || zf;    // LE
      3'b110:  condMet = vf;          // OV
      default: condMet = 1'b1;        // Unconditional
    endcase
  end

  // Offset counts halfwords
  assign offsetExt = {{(`dataWidth-10){offset[8]}}, offset, 1'b0};

  always_comb begin
    result             = '0;
    result.isBr        = isBr;
    result.actualTaken = isBranch && condMet;
    // BR jumps through rs, B is PC relative
    result.branchTarget = isBr ? rsData : (pcNext + offsetExt);
    // Fall through on not taken
    result.actualTarget = result.actualTaken ? result.branchTarget : pcNext;
    result.wenBht       = isBranch;   // Every branch trains the BHT
    // BTB only learns a taken target it got wrong
    result.wenBtb = result.actualTaken && (predictedTarget != result.branchTarget);
    // Redirect needs the fetch PC, resolved in the decode stage
    result.updatePc = 1'b0;
  end

endmodule

//--- src/registerFile.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module registerFile import cpuPkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [`regIdWidth-1:0] srcReg1,
  input  logic [`regIdWidth-1:0] srcReg2,
  input  writeBackT              writeBack,
  output logic [`dataWidth-1:0]  srcData1,
  output logic [`dataWidth-1:0]  srcData2
);

  logic [`dataWidth-1:0] regs [`regCount];
  logic                  writeLive;   // Real write, never to register 0
  logic                  bypass1;
  logic                  bypass2;

  assign writeLive = writeBack.regWrite && (writeBack.regRd != '0);

  // Same-cycle write forwards straight to the read ports
  assign bypass1  = writeLive && (writeBack.regRd == srcReg1);
  assign bypass2  = writeLive && (writeBack.regRd == srcReg2);
  assign srcData1 = bypass1 ? writeBack.data : regs[srcReg1];
  assign srcData2 = bypass2 ? writeBack.data : regs[srcReg2];

  always_ff @(posedge clk) begin
    if (reset) begin
      regs <= '{default: '0};
    end else if (writeLive) begin
      regs[writeBack.regRd] <= writeBack.data;
    end
  end

  // Register 0 reads zero on both ports, bypass included
  reg0Port1: assert property (@(posedge clk) disable iff (reset)
    (srcReg1 == '0) |-> (srcData1 == '0));
  reg0Port2: assert property (@(posedge clk) disable iff (reset)
    (srcReg2 == '0) |-> (srcData2 == '0));

endmodule

//--- src/decodeStage.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module decodeStage import cpuPkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  instrT                 instr,
  input  logic [`dataWidth-1:0] pcCurr,
  input  logic [`dataWidth-1:0] pcNext,
  input  logic [`flagCount-1:0] flags,
  input  logic [`dataWidth-1:0] predictedTarget,
  input  writeBackT             writeBack,
  output exSignalsT             exSig,
  output memSignalsT            memSig,
  output wbSignalsT             wbSig,
  output branchResultT          branch
);

  ctrlT                   ctrl;
  logic                   isNop;      // All-zero word
  logic                   isBr;       // Register-indirect branch
  logic [`regIdWidth-1:0] srcReg1;
  logic [`regIdWidth-1:0] srcReg2;
  logic [`dataWidth-1:0]  srcData1;
  logic [`dataWidth-1:0]  srcData2;
  logic [`dataWidth-1:0]  aluImm;
  branchResultT           bcResult;   // Before the fetch PC compare

  assign isNop = (instr == '0);

  controlUnit controlUnit_i (
    .opcode (instr.r.opcode),
    .ctrl   (ctrl)
  );

  ////////////////////////////////////////////////////////////
  // Register file access
  ////////////////////////////////////////////////////////////
  assign srcReg1 = ctrl.regSrc ? instr.r.rd : instr.r.rs;     // LLB/LHB merge into rd
  assign srcReg2 = ctrl.memWrite ? instr.r.rd : instr.r.rt;   // SW stores rd

  registerFile registerFile_i (
    .clk       (clk),
    .reset     (reset),
    .srcReg1   (srcReg1),
    .srcReg2   (srcReg2),
    .writeBack (writeBack),
    .srcData1  (srcData1),
    .srcData2  (srcData2)
  );

  // Immediate select
  always_comb begin
    if (ctrl.regSrc) begin
      aluImm = {{(`dataWidth-8){1'b0}}, instr.r.rs, instr.r.rt};   // 8-bit byte immediate
    end else if (ctrl.memEnable) begin
      aluImm = {{(`dataWidth-4){instr.r.rt[3]}}, instr.r.rt};      // Signed word offset
    end else begin
      aluImm = {{(`dataWidth-4){1'b0}}, instr.r.rt};               // Shift amount
    end
  end

  ////////////////////////////////////////////////////////////
  // Branch resolution
  ////////////////////////////////////////////////////////////
  assign isBr = ctrl.isBranch && (instr.b.opcode == opBr);

  branchControl branchControl_i (
    .cond            (instr.b.cond),
    .offset          (instr.b.offset),
    .flags           (flags),
    .rsData          (srcData1),     // rs is srcReg1 for BR
    .isBranch        (ctrl.isBranch),
    .isBr            (isBr),
    .pcNext          (pcNext),
    .predictedTarget (predictedTarget),
    .result          (bcResult)
  );

  // Redirect when fetch went somewhere else
  always_comb begin
    branch          = bcResult;
    branch.updatePc = ctrl.isBranch && (bcResult.actualTarget != pcCurr);
  end

  // Bundle packing, NOP leaves everything zero
  always_comb begin
    exSig  = '0;
    memSig = '0;
    wbSig  = '0;
    if (!isNop) begin
      exSig.srcReg1       = srcReg1;
      exSig.srcReg2       = srcReg2;
      exSig.aluIn1        = srcData1;
      exSig.aluImm        = aluImm;
      exSig.aluIn2        = srcData2;   // Execute picks imm or reg by aluSrc
      exSig.aluOp         = ctrl.aluOp;
      exSig.aluSrc        = ctrl.aluSrc;
      exSig.zEn           = ctrl.zEn;
      exSig.nvEn          = ctrl.nvEn;
      memSig.memWriteData = srcData2;
      memSig.memEnable    = ctrl.memEnable;
      memSig.memWrite     = ctrl.memWrite;
      wbSig.regRd         = instr.r.rd;
      wbSig.regWrite      = ctrl.regWrite;
      wbSig.memToReg      = ctrl.memToReg;
      wbSig.hlt           = ctrl.hlt;
      wbSig.pcs           = ctrl.pcs;
    end
  end

endmodule

//--- src/idExRegister.sv
`timescale 1ns/1ps

module idExRegister import cpuPkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       stall,
  input  logic       flush,
  input  exSignalsT  exIn,
  input  memSignalsT memIn,
  input  wbSignalsT  wbIn,
  output exSignalsT  exOut,
  output memSignalsT memOut,
  output wbSignalsT  wbOut
);

  // Flush wins over stall, a squashed slot becomes a bubble
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      exOut  <= '0;
      memOut <= '0;
      wbOut  <= '0;
    end else if (!stall) begin
      exOut  <= exIn;
      memOut <= memIn;
      wbOut  <= wbIn;
    end
  end

  // Bubble after flush commits nothing
  flushBubble: assert property (@(posedge clk) disable iff (reset)
    flush |=> (!wbOut.regWrite && !memOut.memWrite));

  // Stalled slot keeps its instruction
  stallHold: assert property (@(posedge clk) disable iff (reset)
    (stall && !flush) |=> ($stable(exOut) && $stable(wbOut)));

endmodule

//--- src/decodePipeTop.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module decodePipeTop import cpuPkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  instrT                 instr,
  input  logic [`dataWidth-1:0] pcCurr,
  input  logic [`dataWidth-1:0] pcNext,
  input  logic [`flagCount-1:0] flags,
  input  logic [`dataWidth-1:0] predictedTarget,
  input  writeBackT             writeBack,
  input  logic                  stall,
  input  logic                  flush,
  output exSignalsT             exOut,
  output memSignalsT            memOut,
  output wbSignalsT             wbOut,
  output branchResultT          branch
);

  exSignalsT  exSig;    // Decode to ID/EX
  memSignalsT memSig;
  wbSignalsT  wbSig;

  decodeStage decodeStage_i (
    .clk (clk), .reset (reset), .instr (instr), .pcCurr (pcCurr), .pcNext (pcNext),
    .flags (flags), .predictedTarget (predictedTarget), .writeBack (writeBack),
    .exSig (exSig), .memSig (memSig), .wbSig (wbSig), .branch (branch)
  );

  idExRegister idExRegister_i (
    .clk (clk), .reset (reset), .stall (stall), .flush (flush),
    .exIn (exSig), .memIn (memSig), .wbIn (wbSig),
    .exOut (exOut), .memOut (memOut), .wbOut (wbOut)
  );

endmodule

//--- dv/decodeTb.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module decodeTb import cpuPkg::*; ();

  localparam int clkPeriod   = 40;
  localparam int resetCycles = 3;
  // Reset, then each test in order, then the drain cycle
  localparam int totalCycles = resetCycles + 19 + 41 + 24 + 4 + 40 + 6 + 1;

  logic                  clk;
  logic                  reset;
  instrT                 instr;
  logic [`dataWidth-1:0] pcCurr;
  logic [`dataWidth-1:0] pcNext;
  logic [`flagCount-1:0] flags;
  logic [`dataWidth-1:0] predictedTarget;
  writeBackT             writeBack;
  logic                  stall;
  logic                  flush;
  exSignalsT             exOut;
  memSignalsT            memOut;
  wbSignalsT             wbOut;
  branchResultT          branch;

  ////////////////////////////////////////////////////////////
  // Reference model state
  ////////////////////////////////////////////////////////////
  logic [`dataWidth-1:0] shadow [`regCount];   // Architectural registers
  exSignalsT             modelEx;              // Expected ID/EX contents
  memSignalsT            modelMem;
  wbSignalsT             modelWb;
  exSignalsT             pendEx;               // Decoded last cycle
  memSignalsT            pendMem;
  wbSignalsT             pendWb;
  logic                  pendStall;
  logic                  pendFlush;
  logic [`flagCount-1:0] nextFlags;            // Branch inputs for the next issue
  logic [`dataWidth-1:0] nextPcCurr;
  logic [`dataWidth-1:0] nextPcNext;
  logic [`dataWidth-1:0] nextPred;
  integer                seed;

  decodePipeTop dut_i (
    .clk (clk), .reset (reset), .instr (instr), .pcCurr (pcCurr), .pcNext (pcNext),
    .flags (flags), .predictedTarget (predictedTarget), .writeBack (writeBack),
    .stall (stall), .flush (flush),
    .exOut (exOut), .memOut (memOut), .wbOut (wbOut), .branch (branch)
  );

  always #(clkPeriod / 2) clk = ~clk;

  function automatic logic [31:0] nextRandom();
    return $random(seed);
  endfunction

  function automatic instrT makeR(input opcodeT op, input logic [3:0] rd,
                                  input logic [3:0] rs, input logic [3:0] rt);
    instrT ins;
    ins.r.opcode = op;
    ins.r.rd     = rd;
    ins.r.rs     = rs;
    ins.r.rt     = rt;   // Low nibble, immediate for shifts and memory
    return ins;
  endfunction

  function automatic instrT makeB(input opcodeT op, input logic [2:0] cond,
                                  input logic [8:0] offset);
    instrT ins;
    ins.b.opcode = op;
    ins.b.cond   = cond;
    ins.b.offset = offset;
    return ins;
  endfunction

  function automatic writeBackT makeWrite(input logic en, input logic [3:0] rd,
                                          input logic [15:0] data);
    writeBackT wbIn;
    wbIn.regWrite = en;
    wbIn.regRd    = rd;
    wbIn.data     = data;
    return wbIn;
  endfunction

  function automatic writeBackT idleWrite();
    return makeWrite(1'b0, 4'd0, 16'd0);
  endfunction

  // Register read as the ISA sees it, same-cycle write forwarded
  function automatic logic [`dataWidth-1:0] readModel(input logic [3:0] id,
                                                      input writeBackT wbIn);
    if (id == 4'd0) return '0;
    if (wbIn.regWrite && wbIn.regRd == id) return wbIn.data;
    return shadow[id];
  endfunction

  // Flags arrive as {ZF, VF, NF}
  function automatic logic condHolds(input logic [2:0] cond, input logic [2:0] f);
    logic z;
    logic v;
    logic n;
    z = f[2];
    v = f[1];
    n = f[0];
    case (cond)
      3'd0:    return !z;
      3'd1:    return z;
      3'd2:    return !z && !n;
      3'd3:    return n;
      3'd4:    return z || !n;
      3'd5:    return n || z;
      3'd6:    return v;
      default: return 1'b1;
    endcase
  endfunction

  function automatic branchResultT expectBranch(input instrT ins, input writeBackT wbIn);
    branchResultT res;
    logic         isBranch;
    logic [15:0]  offsetBytes;
    res              = '0;
    isBranch         = (ins.b.opcode == opB) || (ins.b.opcode == opBr);
    offsetBytes      = {{6{ins.b.offset[8]}}, ins.b.offset, 1'b0};
    res.isBr         = (ins.b.opcode == opBr);
    res.actualTaken  = isBranch && condHolds(ins.b.cond, flags);
    res.branchTarget = res.isBr ? readModel(ins.r.rs, wbIn) : pcNext + offsetBytes;
    res.actualTarget = res.actualTaken ? res.branchTarget : pcNext;
    res.wenBht       = isBranch;
    res.wenBtb       = res.actualTaken && (predictedTarget != res.branchTarget);
    res.updatePc     = isBranch && (res.actualTarget != pcCurr);
    return res;
  endfunction

  // Expected bundles, straight from the opcode table
  task automatic expectDecode(input instrT ins, input writeBackT wbIn, output exSignalsT ex,
                              output memSignalsT mem, output wbSignalsT wb);
    opcodeT     op;
    logic [3:0] s1;
    logic [3:0] s2;
    ex  = '0;
    mem = '0;
    wb  = '0;
    op  = ins.r.opcode;
    if (ins != '0) begin
      s1 = (op == opLlb || op == opLhb) ? ins.r.rd : ins.r.rs;
      s2 = (op == opSw) ? ins.r.rd : ins.r.rt;
      ex.srcReg1 = s1;
      ex.srcReg2 = s2;
      ex.aluIn1  = readModel(s1, wbIn);
      ex.aluIn2  = readModel(s2, wbIn);
      if (op == opLlb || op == opLhb) ex.aluImm = {8'h00, ins.r.rs, ins.r.rt};
      else if (op == opLw || op == opSw) ex.aluImm = {{12{ins.r.rt[3]}}, ins.r.rt};
      else ex.aluImm = {12'h000, ins.r.rt};
      ex.aluOp  = op;
      ex.aluSrc = op inside {opSll, opSra, opRor, opLw, opSw, opLlb, opLhb};
      ex.zEn    = op inside {opAdd, opSub, opXor, opSll, opSra, opRor};
      ex.nvEn   = op inside {opAdd, opSub, opPaddsb};
      mem.memWriteData = ex.aluIn2;
      mem.memEnable    = op inside {opLw, opSw};
      mem.memWrite     = (op == opSw);
      wb.regRd    = ins.r.rd;
      wb.regWrite = op inside {opAdd, opSub, opXor, opRed, opSll, opSra, opRor, opPaddsb,
                               opLw, opLlb, opLhb, opPcs};
      wb.memToReg = (op == opLw);
      wb.hlt      = (op == opHlt);
      wb.pcs      = (op == opPcs);
    end
  endtask

  task automatic failRun(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic checkWord(input string what, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else
      failRun($sformatf("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp));
  endtask

  ////////////////////////////////////////////////////////////
  // One instruction per cycle, checked at the falling edge
  ////////////////////////////////////////////////////////////
  task automatic issue(input instrT ins, input writeBackT wbIn, input logic stallIn,
                       input logic flushIn);
    exSignalsT  ex;
    memSignalsT mem;
    wbSignalsT  wb;
    @(posedge clk);
    instr           <= ins;
    writeBack       <= wbIn;
    stall           <= stallIn;
    flush           <= flushIn;
    flags           <= nextFlags;
    pcCurr          <= nextPcCurr;
    pcNext          <= nextPcNext;
    predictedTarget <= nextPred;
    @(negedge clk);
    // ID/EX took the last bundle at this edge, flush beats stall
    if (pendFlush) begin
      modelEx  = '0;
      modelMem = '0;
      modelWb  = '0;
    end else if (!pendStall) begin
      modelEx  = pendEx;
      modelMem = pendMem;
      modelWb  = pendWb;
    end
    checkWord("exOut", 64'(exOut), 64'(modelEx));
    checkWord("memOut", 64'(memOut), 64'(modelMem));
    checkWord("wbOut", 64'(wbOut), 64'(modelWb));
    checkWord("branch", 64'(branch), 64'(expectBranch(ins, wbIn)));   // Same cycle
    expectDecode(ins, wbIn, ex, mem, wb);
    pendEx    = ex;
    pendMem   = mem;
    pendWb    = wb;
    pendStall = stallIn;
    pendFlush = flushIn;
    if (wbIn.regWrite && wbIn.regRd != 4'd0) shadow[wbIn.regRd] = wbIn.data;   // Lands at edge
  endtask

  task automatic testReset();
    @(negedge clk);
    checkWord("exOut after reset", 64'(exOut), 64'd0);
    checkWord("memOut after reset", 64'(memOut), 64'd0);
    checkWord("wbOut after reset", 64'(wbOut), 64'd0);
    for (int i = 0; i < `regCount; i++) begin
      issue(makeR(opXor, 4'd1, 4'(i), 4'(i)), idleWrite(), 1'b0, 1'b0);
    end
    issue(makeR(opAdd, 4'd2, 4'd0, 4'd0), makeWrite(1'b1, 4'd0, 16'hbeef), 1'b0, 1'b0);
    issue(makeR(opAdd, 4'd2, 4'd0, 4'd0), idleWrite(), 1'b0, 1'b0);   // r0 still zero
  endtask

  task automatic testRegWrites();
    logic [31:0] r;
    logic [31:0] w;
    for (int i = 1; i < `regCount; i++) begin
      r = nextRandom();
      issue('0, makeWrite(1'b1, 4'(i), r[15:0]), 1'b0, 1'b0);
    end
    repeat (24) begin
      r = nextRandom();
      w = nextRandom();
      issue(makeR(opcodeT'({1'b0, r[2:0]}), r[7:4], r[11:8], r[15:12]),
            makeWrite(w[0], w[4:1], w[31:16]), 1'b0, 1'b0);
    end
    issue(makeR(opSub, 4'd3, 4'd5, 4'd5), makeWrite(1'b1, 4'd5, 16'h5a5a), 1'b0, 1'b0);
    issue(makeR(opSub, 4'd3, 4'd5, 4'd5), idleWrite(), 1'b0, 1'b0);
    checkWord("bypassed aluIn1", 64'(exOut.aluIn1), 64'h5a5a);
  endtask

  task automatic testImmediates();
    logic [31:0] r;
    repeat (4) begin
      r = nextRandom();
      issue(makeR(opLw, r[3:0], r[7:4], r[11:8]), idleWrite(), 1'b0, 1'b0);
      issue(makeR(opSll, r[7:4], r[11:8], r[15:12]), idleWrite(), 1'b0, 1'b0);
      issue(makeR(opLlb, r[11:8], r[15:12], r[19:16]), idleWrite(), 1'b0, 1'b0);
      issue(makeR(opLhb, r[15:12], r[19:16], r[23:20]), idleWrite(), 1'b0, 1'b0);
      issue(makeR(opSw, r[19:16], r[23:20], r[27:24]), idleWrite(), 1'b0, 1'b0);
    end
    issue(makeR(opLw, 4'd1, 4'd2, 4'hc), idleWrite(), 1'b0, 1'b0);
    issue(makeR(opSll, 4'd1, 4'd2, 4'hc), idleWrite(), 1'b0, 1'b0);
    checkWord("LW aluImm", 64'(exOut.aluImm), 64'hfffc);   // Sign-extended
    issue(makeR(opLlb, 4'd6, 4'ha, 4'h5), idleWrite(), 1'b0, 1'b0);
    checkWord("SLL aluImm", 64'(exOut.aluImm), 64'h000c);
    issue('0, idleWrite(), 1'b0, 1'b0);
    checkWord("LLB aluImm", 64'(exOut.aluImm), 64'h00a5);
    checkWord("LLB srcReg1", 64'(exOut.srcReg1), 64'd6);
  endtask

  task automatic testSpecial();
    issue('0, idleWrite(), 1'b0, 1'b0);
    issue(makeR(opHlt, 4'd0, 4'd0, 4'd0), idleWrite(), 1'b0, 1'b0);
    issue(makeR(opPcs, 4'd7, 4'd0, 4'd0), idleWrite(), 1'b0, 1'b0);
    checkWord("HLT hlt bit", 64'(wbOut.hlt), 64'd1);
    issue('0, idleWrite(), 1'b0, 1'b0);
    checkWord("PCS pcs bit", 64'(wbOut.pcs), 64'd1);
  endtask

  task automatic testBranches();
    logic [31:0] r;
    logic [31:0] w;
    instrT       ins;
    logic [15:0] target;   // Where the branch goes when taken
    repeat (40) begin
      r          = nextRandom();
      w          = nextRandom();
      ins        = makeB(r[4] ? opBr : opB, r[7:5], r[16:8]);
      nextFlags  = r[2:0];
      nextPcNext = {w[15:1], 1'b0};
      target     = r[4] ? readModel(ins.r.rs, idleWrite())
                        : nextPcNext + {{6{ins.b.offset[8]}}, ins.b.offset, 1'b0};
      nextPred   = w[0] ? target : r[31:16];         // BTB sometimes already right
      nextPcCurr = r[3] ? nextPcNext : w[31:16];   // Sometimes fetch fell through
      issue(ins, idleWrite(), 1'b0, 1'b0);
    end
  endtask

  task automatic testStallFlush();
    issue(makeR(opAdd, 4'd9, 4'd1, 4'd2), idleWrite(), 1'b0, 1'b0);
    repeat (3) begin
      issue(makeR(opXor, 4'd8, 4'd3, 4'd4), makeWrite(1'b1, 4'd4, 16'h1234), 1'b1, 1'b0);
      checkWord("stalled regRd", 64'(wbOut.regRd), 64'd9);   // ADD still held
    end
    issue(makeR(opSub, 4'd8, 4'd4, 4'd4), idleWrite(), 1'b1, 1'b1);
    issue('0, idleWrite(), 1'b0, 1'b0);
    checkWord("flushed exOut", 64'(exOut), 64'd0);
    checkWord("flushed wbOut", 64'(wbOut), 64'd0);
  endtask

  // Watchdog at twice the planned length
  initial begin
    #(2 * totalCycles * clkPeriod);
    failRun("Timeout: the tests did not finish within the expected time");
  end

  initial begin
    seed            = 32'h33a12dd2;
    clk             = 1'b0;
    reset           = 1'b1;
    instr           = '0;                  // NOP during reset
    pcCurr          = '0;
    pcNext          = '0;
    flags           = '0;
    predictedTarget = '0;
    writeBack       = '0;
    stall           = 1'b0;
    flush           = 1'b0;
    nextFlags       = '0;
    nextPcCurr      = '0;
    nextPcNext      = '0;
    nextPred        = '0;
    modelEx         = '0;
    modelMem        = '0;
    modelWb         = '0;
    pendEx          = '0;
    pendMem         = '0;
    pendWb          = '0;
    pendStall       = 1'b0;
    pendFlush       = 1'b0;
    for (int i = 0; i < `regCount; i++) shadow[i] = '0;
    repeat (resetCycles) @(posedge clk);
    reset <= 1'b0;
    testReset();
    testRegWrites();
    testImmediates();
    testSpecial();
    testBranches();
    testStallFlush();
    issue('0, idleWrite(), 1'b0, 1'b0);   // Drain the last bundle
    $display("All tests passed");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+src
src/cpuPkg.sv
src/controlUnit.sv
src/branchControl.sv
src/registerFile.sv
src/decodeStage.sv
src/idExRegister.sv
src/decodePipeTop.sv
dv/decodeTb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run the testbench, judge the run by its log
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -f verilog.f --top-module decodeTb -o decodeSim &&
./obj_dir/decodeSim | tee sim.log
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
